// File: run_sim.sh
#!/bin/sh
# Build with Verilator, run, then judge the simulation log
rm -f sim.log
verilator --binary --timing --top-module tb_note_trainer -f src.f > build.log 2>&1 \
    && ./obj_dir/Vtb_note_trainer > sim.log 2>&1 \
    || { echo "Build or run error, see build.log and sim.log"; exit 1; }
grep -q "CHECKS FAILED" sim.log \
    && { echo "Simulation reported failures, see sim.log"; exit 1; } \
    || { echo "Simulation finished without failures"; exit 0; }

// File: source/game_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module game_fsm
    import note_game_pkg::*;
#(
    parameter int song_length = 62
)
(
    input  wire          clk,
    input  wire          rst,
    input  wire          key,
    input  wire          note_valid,
    input  wire note_t   note,
    output game_status_t status
);

    localparam logic [5:0] last_index = 6'(song_length - 1);

    logic prev_key;
    logic key_pressed;
    logic last_note;

    // ----------------------------------------
    // Key edge
    // ----------------------------------------

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            prev_key    <= 1'b0;
            key_pressed <= 1'b0;
        end
        else
        begin
            prev_key    <= key;
            key_pressed <= key & ~prev_key;
        end
    end

    // ----------------------------------------
    // Game state
    // ----------------------------------------

    assign last_note = (status.note_index == last_index);

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            status.state      <= idle;
            status.note_index <= '0;
            status.hit        <= 1'b0;
            status.miss       <= 1'b0;
        end
        else
        begin
            case (status.state)
                idle:
                begin
                    status.hit  <= 1'b0;
                    status.miss <= 1'b0;
                    if (key_pressed)
                    begin
                        status.state      <= playing;
                        status.note_index <= '0;
                    end
                end
                playing:
                begin
                    if (key_pressed)
                    begin
                        // Abort the run
                        status.state <= idle;
                        status.hit   <= 1'b0;
                        status.miss  <= 1'b0;
                    end
                    else if (note_valid)
                    begin
                        if (note == song_table[status.note_index])
                        begin
                            status.hit  <= 1'b1;
                            status.miss <= 1'b0;
                            if (last_note)
                                status.state <= win;
                            else
                                status.note_index <= status.note_index + 1'b1;
                        end
                        else
                        begin
                            status.hit        <= 1'b0;
                            status.miss       <= 1'b1;
                            status.note_index <= '0;
                            status.state      <= fail;
                        end
                    end
                end
                fail:
                begin
                    status.note_index <= '0;
                    if (key_pressed)
                    begin
                        status.state <= idle;
                        status.hit   <= 1'b0;
                        status.miss  <= 1'b0;
                    end
                end
                default:
                begin
                    // Win holds the final index until the key
                    if (key_pressed)
                    begin
                        status.state <= idle;
                        status.hit   <= 1'b0;
                        status.miss  <= 1'b0;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: source/note_classifier.sv
`timescale 1ns/1ps
`default_nettype none

module note_classifier
    import note_game_pkg::*;
#(
    parameter int clk_mhz  = 50,
    parameter int w_period = 20
)
(
    input  wire                 clk,
    input  wire                 rst,
    input  wire [w_period-1:0]  period,
    output note_t               raw_note
);

    // Cycles per wave for a table frequency scaled by mult
    function automatic logic [63:0] nominal_period(input logic [18:0] freq, input int mult);
        return 64'(clk_mhz) * 64'd100_000_000 / (64'(freq) * 64'(mult));
    endfunction

    // Strictly inside the +-3 % window around nom
    function automatic logic in_window(input logic [w_period-1:0] p, input logic [63:0] nom);
        logic [63:0] lo;
        logic [63:0] hi;
        lo = nom * 64'd97 / 64'd100;
        hi = nom * 64'd103 / 64'd100;
        return (64'(p) > lo) && (64'(p) < hi);
    endfunction

    logic [11:0] match;
    note_t       next_note;

    for (genvar i = 0; i < 12; i++)
    begin : g_semitone
        assign match[11 - i] = in_window(period, nominal_period(freq_table[i], 1))
                             | in_window(period, nominal_period(freq_table[i], 2))
                             | in_window(period, nominal_period(freq_table[i], 4));
    end

    // Windows of neighbours overlap slightly, the higher bit wins
    always_comb
    begin
        next_note = no_note;
        for (int i = 0; i < 12; i++)
            if (match[i])
                next_note = note_t'(1) << i;
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            raw_note <= no_note;
        else
            raw_note <= next_note;
    end

endmodule

`default_nettype wire

// File: source/note_display.sv
`timescale 1ns/1ps
`default_nettype none

module note_display
    import note_game_pkg::*;
(
    input  wire   clk,
    input  wire   rst,
    input  wire   note_t stable_note,
    output seg_t  abcdefgh
);

    seg_t pattern;

    // Anything but a single semitone shows the dash
    always_comb
    begin
        pattern = seg_table[12];
        for (int i = 0; i < 12; i++)
            if (stable_note == (note_c >> i))
                pattern = seg_table[i];
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            abcdefgh <= '0;
        else
            abcdefgh <= pattern;
    end

endmodule

`default_nettype wire

// File: source/note_game_pkg.sv
`default_nettype none

package note_game_pkg;

    // ----------------------------------------
    // Basic word types
    // ----------------------------------------

    typedef logic signed [23:0] mic_sample_t;
    typedef logic        [11:0] note_t;
    typedef logic        [ 7:0] seg_t;

    // One-hot semitones, C in the top bit
    localparam note_t no_note  = 12'b0000_0000_0000;
    localparam note_t note_c   = 12'b1000_0000_0000;
    localparam note_t note_cs  = 12'b0100_0000_0000;
    localparam note_t note_d   = 12'b0010_0000_0000;
    localparam note_t note_ds  = 12'b0001_0000_0000;
    localparam note_t note_e   = 12'b0000_1000_0000;
    localparam note_t note_f   = 12'b0000_0100_0000;
    localparam note_t note_fs  = 12'b0000_0010_0000;
    localparam note_t note_g   = 12'b0000_0001_0000;
    localparam note_t note_gs  = 12'b0000_0000_1000;
    localparam note_t note_a   = 12'b0000_0000_0100;
    localparam note_t note_as  = 12'b0000_0000_0010;
    localparam note_t note_b   = 12'b0000_0000_0001;

    // Lowest octave, frequency in Hz times 100, C first
    localparam logic [18:0] freq_table [12] = '{
        19'd26163, 19'd27718, 19'd29366, 19'd31113,
        19'd32963, 19'd34923, 19'd36999, 19'd39200,
        19'd41530, 19'd44000, 19'd46616, 19'd49388
    };

    // ----------------------------------------
    // Song
    // ----------------------------------------

    localparam int song_max = 62;

    localparam note_t song_table [song_max] = '{
        note_e, note_g, note_d, note_c, note_d, note_e, note_g, note_d,
        note_e, note_g, note_d, note_c, note_g, note_f, note_e, note_d,
        note_e, note_g, note_d, note_c, note_d, note_e, note_g, note_d,
        note_e, note_g, note_d, note_c, note_g,
        note_g, note_f, note_e, note_f, note_e, note_c,
        note_f, note_e, note_d, note_e, note_d, note_a,
        note_g, note_f, note_e, note_f, note_e, note_c, note_f, note_c,
        note_e, note_g, note_d, note_c, note_d, note_e, note_g, note_d,
        note_e, note_g, note_d, note_c, note_g
    };

    // ----------------------------------------
    // Display patterns, abcdefgh
    // ----------------------------------------

    // Entries 0..11 follow C..B, entry 12 is the dash
    localparam seg_t seg_table [13] = '{
        8'b1001_1100, 8'b1001_1101, 8'b0111_1010, 8'b0111_1011,
        8'b1001_1110, 8'b1000_1110, 8'b1000_1111, 8'b1011_1100,
        8'b1011_1101, 8'b1110_1110, 8'b1110_1111, 8'b0011_1110,
        8'b0000_0010
    };

    // ----------------------------------------
    // Game
    // ----------------------------------------

    typedef enum logic [1:0] {
        idle,
        playing,
        win,
        fail
    } game_state_t;

    typedef struct packed {
        game_state_t state;
        logic [5:0]  note_index;
        logic        hit;
        logic        miss;
    } game_status_t;

endpackage

`default_nettype wire

// File: source/note_stabilizer.sv
`timescale 1ns/1ps
`default_nettype none

module note_stabilizer
    import note_game_pkg::*;
#(
    parameter int w_hold = 20
)
(
    input  wire   clk,
    input  wire   rst,
    input  wire   note_t raw_note,
    output note_t stable_note,
    output logic  note_valid,
    output note_t note
);

    note_t             d_note;
    logic [w_hold-1:0] hold_cnt;
    logic              steady;
    logic              accept;
    logic              new_note;

    assign steady   = (raw_note == d_note);
    // Last agreeing cycle of the full hold window
    assign accept   = steady && (hold_cnt == '1);
    assign new_note = (d_note != stable_note) && (d_note != no_note);

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            d_note      <= no_note;
            hold_cnt    <= '0;
            stable_note <= no_note;
            note_valid  <= 1'b0;
        end
        else
        begin
            d_note     <= raw_note;
            hold_cnt   <= steady ? hold_cnt + 1'b1 : '0;
            note_valid <= accept && new_note;
            if (accept)
                stable_note <= d_note;
        end
    end

    // Payload of the last note event
    always_ff @(posedge clk)
    begin
        if (accept && new_note)
            note <= d_note;
    end

endmodule

`default_nettype wire

// File: source/note_trainer_top.sv
`timescale 1ns/1ps
`default_nettype none

module note_trainer_top
    import note_game_pkg::*;
#(
    parameter int clk_mhz     = 50,
    parameter int w_period    = 20,
    parameter int w_hold      = 20,
    parameter int song_length = 62
)
(
    input  wire          clk,
    input  wire          rst,
    input  wire          mic_sample_t mic,
    input  wire          key,
    output seg_t         abcdefgh,
    output game_status_t status
);

    logic [w_period-1:0] period;
    note_t               raw_note;
    note_t               stable_note;
    logic                note_valid;
    note_t               note;

    // ----------------------------------------
    // Pitch path
    // ----------------------------------------

    period_timer #(
        .w_period (w_period)
    ) u_period_timer (
        .clk    (clk),
        .rst    (rst),
        .mic    (mic),
        .period (period)
    );

    note_classifier #(
        .clk_mhz  (clk_mhz),
        .w_period (w_period)
    ) u_note_classifier (
        .clk      (clk),
        .rst      (rst),
        .period   (period),
        .raw_note (raw_note)
    );

    note_stabilizer #(
        .w_hold (w_hold)
    ) u_note_stabilizer (
        .clk         (clk),
        .rst         (rst),
        .raw_note    (raw_note),
        .stable_note (stable_note),
        .note_valid  (note_valid),
        .note        (note)
    );

    // ----------------------------------------
    // Display and game
    // ----------------------------------------

    note_display u_note_display (
        .clk         (clk),
        .rst         (rst),
        .stable_note (stable_note),
        .abcdefgh    (abcdefgh)
    );

    game_fsm #(
        .song_length (song_length)
    ) u_game_fsm (
        .clk        (clk),
        .rst        (rst),
        .key        (key),
        .note_valid (note_valid),
        .note       (note),
        .status     (status)
    );

endmodule

`default_nettype wire

// File: source/period_timer.sv
`timescale 1ns/1ps
`default_nettype none

module period_timer
    import note_game_pkg::*;
#(
    parameter int w_period = 20
)
(
    input  wire                  clk,
    input  wire                  rst,
    input  wire mic_sample_t     mic,
    output logic [w_period-1:0]  period
);

    mic_sample_t         prev_mic;
    logic [w_period-1:0] counter;
    logic                crossing;

    // Negative to non-negative step of the sample
    assign crossing = prev_mic[$left(prev_mic)] & ~mic[$left(mic)];

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            prev_mic <= '0;
            counter  <= '0;
            period   <= '0;
        end
        else
        begin
            prev_mic <= mic;
            if (crossing)
            begin
                period  <= counter;
                counter <= '0;
            end
            else if (counter == '1)
                period <= '1;   // silence, reads as out of range
            else
                counter <= counter + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: src.f
+incdir+tests
source/note_game_pkg.sv
source/period_timer.sv
source/note_classifier.sv
source/note_stabilizer.sv
source/note_display.sv
source/game_fsm.sv
source/note_trainer_top.sv
tests/tb_note_trainer.sv

// File: tests/tb_checks.svh
`ifndef tb_checks_svh
`define tb_checks_svh

// Error counters, reported in the closing line
int value_errors = 0;
int event_errors = 0;

task automatic check_note(input int row, input string name, input note_t got, input note_t exp);
    if (got !== exp)
    begin
        $display("FAIL row %0d %s: got 0x%h expected 0x%h", row, name, got, exp);
        value_errors++;
    end
endtask

task automatic check_seg(input int row, input string name, input seg_t got, input seg_t exp);
    if (got !== exp)
    begin
        $display("FAIL row %0d %s: got 0x%h expected 0x%h", row, name, got, exp);
        value_errors++;
    end
endtask

task automatic check_status(input int row, input string name,
                            input game_status_t got, input game_status_t exp);
    if (got !== exp)
    begin
        $display("FAIL row %0d %s: got 0x%h expected 0x%h", row, name, got, exp);
        value_errors++;
    end
endtask

// Number of note_valid pulses seen during one row
task automatic check_events(input int row, input int got, input int exp);
    if (got != exp)
    begin
        $display("FAIL row %0d note_valid count: got 0x%h expected 0x%h", row, got, exp);
        event_errors++;
    end
endtask

`endif

// File: tests/tb_note_trainer.sv
`timescale 1ns/1ps
`default_nettype none

module tb_note_trainer
    import note_game_pkg::*;
();

    localparam int clk_mhz        = 1;
    localparam int w_period       = 12;
    localparam int w_hold         = 4;
    localparam int song_length    = 4;
    localparam int reset_cycles   = 8;
    localparam int tone_waves     = 6;
    localparam int silence_cycles = 5000;
    localparam int settle_cycles  = 8;

    localparam mic_sample_t half_pos = 24'sh40_0000;
    localparam mic_sample_t half_neg = -24'sh40_0000;
    localparam seg_t        dash     = seg_table[12];

    typedef enum logic [1:0] {
        act_tone,
        act_silence,
        act_key
    } action_t;

    // One stimulus step with its expected results
    typedef struct packed {
        action_t      action;
        logic [3:0]   tone;
        note_t        exp_note;
        seg_t         exp_seg;
        game_status_t exp_status;
        logic [3:0]   exp_events;
    } row_t;

    logic         clk;
    logic         rst;
    logic         key;
    mic_sample_t  mic;
    seg_t         abcdefgh;
    game_status_t status;

    row_t rows[$];
    int   event_total = 0;
    int   cycle_count = 0;
    int   cycle_limit = 0;

    `include "tb_checks.svh"

    note_trainer_top #(
        .clk_mhz     (clk_mhz),
        .w_period    (w_period),
        .w_hold      (w_hold),
        .song_length (song_length)
    ) dut0 (
        .clk      (clk),
        .rst      (rst),
        .mic      (mic),
        .key      (key),
        .abcdefgh (abcdefgh),
        .status   (status)
    );

    always #50 clk = ~clk;

    // note_valid pulses, counted one edge late
    always @(posedge clk)
    begin
        if (dut0.note_valid)
            event_total++;
    end

    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_limit > 0 && cycle_count > cycle_limit)
        begin
            $display("Timeout after %0d cycles, the run did not finish", cycle_count);
            $display("Errors: %0d value, %0d event", value_errors, event_errors);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    // ----------------------------------------
    // Stimulus helpers
    // ----------------------------------------

    // Cycles per wave of a table note, two octaves up
    function automatic int tone_period(input int idx);
        return (clk_mhz * 100_000_000) / (int'(freq_table[idx]) * 4);
    endfunction

    function automatic int row_length(input row_t r);
        int len;
        case (r.action)
            act_tone:    len = tone_waves * tone_period(int'(r.tone));
            act_silence: len = silence_cycles;
            default:     len = 2;
        endcase
        return len + settle_cycles;
    endfunction

    task automatic add_row(input action_t act, input int tone_idx, input note_t n,
                           input seg_t s, input game_state_t st, input int idx,
                           input logic hit, input logic miss, input int events);
        row_t r;
        r.action                = act;
        r.tone                  = 4'(tone_idx);
        r.exp_note              = n;
        r.exp_seg               = s;
        r.exp_status.state      = st;
        r.exp_status.note_index = 6'(idx);
        r.exp_status.hit        = hit;
        r.exp_status.miss       = miss;
        r.exp_events            = 4'(events);
        rows.push_back(r);
    endtask

    // Low half first, so each wave ends on a crossing-free high
    task automatic play_tone(input int idx);
        int p;
        p = tone_period(idx);
        repeat (tone_waves)
        begin
            mic = half_neg;
            repeat (p - p / 2) @(negedge clk);
            mic = half_pos;
            repeat (p / 2) @(negedge clk);
        end
    endtask

    task automatic press_key();
        key = 1'b1;
        repeat (2) @(negedge clk);
        key = 1'b0;
    endtask

    // ----------------------------------------
    // Stimulus table
    // ----------------------------------------

    task automatic build_table();
        add_row(act_silence, 0, no_note, dash, idle, 0, 1'b0, 1'b0, 0);
        // Every semitone, silence in between
        for (int i = 0; i < 12; i++)
        begin
            add_row(act_tone, i, note_c >> i, seg_table[i], idle, 0, 1'b0, 1'b0, 1);
            add_row(act_silence, 0, no_note, dash, idle, 0, 1'b0, 1'b0, 0);
        end
        // Correct play through E G D C
        add_row(act_key, 0, no_note, dash, playing, 0, 1'b0, 1'b0, 0);
        add_row(act_tone, 4, note_e, seg_table[4], playing, 1, 1'b1, 1'b0, 1);
        add_row(act_silence, 0, no_note, dash, playing, 1, 1'b1, 1'b0, 0);
        add_row(act_tone, 7, note_g, seg_table[7], playing, 2, 1'b1, 1'b0, 1);
        add_row(act_silence, 0, no_note, dash, playing, 2, 1'b1, 1'b0, 0);
        add_row(act_tone, 2, note_d, seg_table[2], playing, 3, 1'b1, 1'b0, 1);
        add_row(act_silence, 0, no_note, dash, playing, 3, 1'b1, 1'b0, 0);
        add_row(act_tone, 0, note_c, seg_table[0], win, 3, 1'b1, 1'b0, 1);
        add_row(act_silence, 0, no_note, dash, win, 3, 1'b1, 1'b0, 0);
        add_row(act_key, 0, no_note, dash, idle, 3, 1'b0, 1'b0, 0);
        // Wrong second note
        add_row(act_key, 0, no_note, dash, playing, 0, 1'b0, 1'b0, 0);
        add_row(act_tone, 4, note_e, seg_table[4], playing, 1, 1'b1, 1'b0, 1);
        add_row(act_silence, 0, no_note, dash, playing, 1, 1'b1, 1'b0, 0);
        add_row(act_tone, 9, note_a, seg_table[9], fail, 0, 1'b0, 1'b1, 1);
        add_row(act_silence, 0, no_note, dash, fail, 0, 1'b0, 1'b1, 0);
        add_row(act_key, 0, no_note, dash, idle, 0, 1'b0, 1'b0, 0);
        // Abort mid run
        add_row(act_key, 0, no_note, dash, playing, 0, 1'b0, 1'b0, 0);
        add_row(act_tone, 4, note_e, seg_table[4], playing, 1, 1'b1, 1'b0, 1);
        add_row(act_silence, 0, no_note, dash, playing, 1, 1'b1, 1'b0, 0);
        add_row(act_key, 0, no_note, dash, idle, 1, 1'b0, 1'b0, 0);
    endtask

    task automatic apply_row(input int num, input row_t r);
        int start;
        start = event_total;
        case (r.action)
            act_tone:
                play_tone(int'(r.tone));
            act_silence:
            begin
                mic = half_pos;
                repeat (silence_cycles) @(negedge clk);
            end
            default:
                press_key();
        endcase
        repeat (settle_cycles) @(negedge clk);
        check_note(num, "stable_note", dut0.stable_note, r.exp_note);
        check_seg(num, "abcdefgh", abcdefgh, r.exp_seg);
        check_status(num, "status", status, r.exp_status);
        check_events(num, event_total - start, int'(r.exp_events));
    endtask

    initial
    begin
        int           total;
        game_status_t reset_status;
        clk = 1'b0;
        rst = 1'b1;
        key = 1'b0;
        mic = half_pos;
        reset_status = '{state: idle, note_index: 6'd0, hit: 1'b0, miss: 1'b0};
        build_table();
        total = reset_cycles;
        foreach (rows[i])
            total += row_length(rows[i]);
        cycle_limit = total + total / 5;

        // Outputs inactive while reset is held
        repeat (reset_cycles) @(negedge clk);
        check_seg(0, "abcdefgh", abcdefgh, 8'h00);
        check_status(0, "status", status, reset_status);
        check_events(0, event_total, 0);
        rst = 1'b0;

        foreach (rows[i])
            apply_row(i + 1, rows[i]);

        $display("Errors: %0d value, %0d event", value_errors, event_errors);
        if (value_errors + event_errors == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

`default_nettype wire
